// File: mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// memory depths in 32-bit words
`define IMEM_WORDS 256
`define DMEM_WORDS 256

// APB byte address map
`define ADDR_IMEM_BASE 12'h000
`define ADDR_DMEM_BASE 12'h400
`define ADDR_CTRL      12'h800
`define ADDR_STATUS    12'h804
`define ADDR_REG_BASE  12'hC00
`define REG_WORDS      32

// project-defined stop word
`define HALT_OPCODE 6'b111111

`endif

// File: mipsPkg.sv
`default_nettype none

package mipsPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [15:0] imm16_t;
    typedef logic [25:0] imm26_t;
    typedef logic [31:0] pc_t; // byte address

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_OR,
        ALU_SLL
    } aluOp_t;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_LUI,
        WB_LINK // pc + 4
    } wbSel_t;

    typedef enum logic [1:0] {EXT_ZERO, EXT_SIGN, EXT_UPPER} extMode_t;

    typedef enum logic [1:0] {MEM_WORD, MEM_HALF, MEM_BYTE} memSize_t;

    typedef enum logic [1:0] {APB_IDLE, APB_SETUP, APB_ACCESS} apbState_t;

endpackage

`default_nettype wire

// File: ctrlIf.sv
`timescale 1ns/1ns
`default_nettype none

interface ctrlIf;
    import mipsPkg::*;

    word_t    instr;
    regAddr_t rs;
    regAddr_t rt;
    regAddr_t rd;
    logic [4:0] shamt;
    imm16_t   imm16;
    imm26_t   imm26;
    aluOp_t   aluOp;
    logic     aluSrc; // 1 selects extended immediate
    extMode_t extMode;
    wbSel_t   wbSel;
    memSize_t memSize;
    logic     memWrite;
    logic     memRead;
    logic     regWrite;
    regAddr_t regAddr;
    logic     beq;
    logic     bgtz;
    logic     bgezal;
    logic     j;
    logic     jal;
    logic     jr;
    logic     jalr;
    logic     halt;

    modport decoder (
        output rs, rt, rd, shamt, imm16, imm26,
        output aluOp, aluSrc, extMode, wbSel, memSize,
        output memWrite, memRead, regWrite, regAddr,
        output beq, bgtz, bgezal, j, jal, jr, jalr, halt
    );

    modport datapath (
        output instr,
        input  rs, rt, rd, shamt, imm16, imm26,
        input  aluOp, aluSrc, extMode, wbSel, memSize,
        input  memWrite, memRead, regWrite, regAddr,
        input  beq, bgtz, bgezal, j, jal, jr, jalr, halt
    );

endinterface

`default_nettype wire

// File: Controller.sv
`timescale 1ns/1ns
`default_nettype none
`include "mips_config.svh"

module Controller (
    input mipsPkg::word_t instr,
    ctrlIf.decoder        ctrl
);
    import mipsPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic isR, isAdd, isSub, isXor, isSll, isJr, isJalr;
    logic isOri, isAddi, isLui, isLw, isLh, isLb, isSw, isSh, isSb;
    logic isBeq, isBgtz, isBgezal, isJ, isJal, isHalt;
    logic calcR, calcI, load, store, branch, link;

    assign opcode     = instr[31:26];
    assign funct      = instr[5:0];
    assign ctrl.rs    = instr[25:21];
    assign ctrl.rt    = instr[20:16];
    assign ctrl.rd    = instr[15:11];
    assign ctrl.shamt = instr[10:6];
    assign ctrl.imm16 = instr[15:0];
    assign ctrl.imm26 = instr[25:0];

    assign isR      = (opcode == 6'b000000);
    assign isAdd    = isR && (funct == 6'b100000);
    assign isSub    = isR && (funct == 6'b100010);
    assign isXor    = isR && (funct == 6'b100110);
    assign isSll    = isR && (funct == 6'b000000);
    assign isJr     = isR && (funct == 6'b001000);
    assign isJalr   = isR && (funct == 6'b001001);
    assign isOri    = (opcode == 6'b001101);
    assign isAddi   = (opcode == 6'b001000);
    assign isLui    = (opcode == 6'b001111);
    assign isLw     = (opcode == 6'b100011);
    assign isLh     = (opcode == 6'b100001);
    assign isLb     = (opcode == 6'b100000);
    assign isSw     = (opcode == 6'b101011);
    assign isSh     = (opcode == 6'b101001);
    assign isSb     = (opcode == 6'b101000);
    assign isBeq    = (opcode == 6'b000100);
    assign isBgtz   = (opcode == 6'b000111);
    assign isBgezal = (opcode == 6'b000001); // rt field not checked
    assign isJ      = (opcode == 6'b000010);
    assign isJal    = (opcode == 6'b000011);
    assign isHalt   = (opcode == `HALT_OPCODE);

    assign calcR  = isAdd | isSub | isXor | isSll;
    assign calcI  = isOri | isAddi;
    assign load   = isLw | isLh | isLb;
    assign store  = isSw | isSh | isSb;
    assign branch = isBeq | isBgtz | isBgezal;
    assign link   = isJal | isJalr | isBgezal; // bgezal links even when not taken

    always_comb begin
        ctrl.aluOp = ALU_ADD;
        if (isSub || isBeq) ctrl.aluOp = ALU_SUB; // beq tests rs - rt
        else if (isXor) ctrl.aluOp = ALU_XOR;
        else if (isOri) ctrl.aluOp = ALU_OR;
        else if (isSll) ctrl.aluOp = ALU_SLL;

        ctrl.extMode = EXT_ZERO;
        if (load || store || branch || isAddi) ctrl.extMode = EXT_SIGN;
        else if (isLui) ctrl.extMode = EXT_UPPER;

        ctrl.wbSel = WB_ALU;
        if (load) ctrl.wbSel = WB_MEM;
        else if (isLui) ctrl.wbSel = WB_LUI;
        else if (link) ctrl.wbSel = WB_LINK;

        ctrl.memSize = MEM_WORD;
        if (isSh || isLh) ctrl.memSize = MEM_HALF;
        else if (isSb || isLb) ctrl.memSize = MEM_BYTE;

        ctrl.regAddr = '0;
        if (calcR || isJalr) ctrl.regAddr = ctrl.rd;
        else if (calcI || load || isLui) ctrl.regAddr = ctrl.rt;
        else if (isJal || isBgezal) ctrl.regAddr = 5'd31;
    end

    assign ctrl.aluSrc   = calcI | load | store;
    assign ctrl.memWrite = store;
    assign ctrl.memRead  = load;
    assign ctrl.regWrite = calcR | calcI | load | isLui | link;
    assign ctrl.beq      = isBeq;
    assign ctrl.bgtz     = isBgtz;
    assign ctrl.bgezal   = isBgezal;
    assign ctrl.j        = isJ;
    assign ctrl.jal      = isJal;
    assign ctrl.jr       = isJr;
    assign ctrl.jalr     = isJalr;
    assign ctrl.halt     = isHalt;

endmodule

`default_nettype wire

// File: Alu.sv
`timescale 1ns/1ns
`default_nettype none

module Alu (
    input  mipsPkg::word_t  a,
    input  mipsPkg::word_t  b,
    input  logic [4:0]      shamt,
    input  mipsPkg::aluOp_t op,
    output mipsPkg::word_t  result,
    output logic            zero,
    output logic            negative
);
    import mipsPkg::*;

    always_comb begin
        case (op)
            ALU_SUB: result = a - b;
            ALU_XOR: result = a ^ b;
            ALU_OR:  result = a | b;
            ALU_SLL: result = b << shamt; // shifts rt, not rs
            default: result = a + b;
        endcase
    end

    assign zero     = (result == '0);
    assign negative = result[31];

endmodule

`default_nettype wire

// File: RegFile.sv
`timescale 1ns/1ns
`default_nettype none

module RegFile (
    input  logic               clk,
    input  logic               arstN,
    input  mipsPkg::regAddr_t  raddrA,
    input  mipsPkg::regAddr_t  raddrB,
    input  mipsPkg::regAddr_t  raddrHost,
    output mipsPkg::word_t     rdataA,
    output mipsPkg::word_t     rdataB,
    output mipsPkg::word_t     rdataHost,
    input  logic               we,
    input  mipsPkg::regAddr_t  waddr,
    input  mipsPkg::word_t     wdata
);
    import mipsPkg::*;

    word_t regs [32];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            regs <= '{default: '0};
        end else if (we && (waddr != '0)) begin // r0 stays zero
            regs[waddr] <= wdata;
        end
    end

    assign rdataA    = regs[raddrA];
    assign rdataB    = regs[raddrB];
    assign rdataHost = regs[raddrHost];

endmodule

`default_nettype wire

// File: DataMem.sv
`timescale 1ns/1ns
`default_nettype none
`include "mips_config.svh"

module DataMem (
    input  logic              clk,
    input  logic              arstN,
    input  logic              en,
    input  logic              we,
    input  mipsPkg::word_t    addr, // byte address
    input  mipsPkg::memSize_t size,
    input  mipsPkg::word_t    wdata,
    output mipsPkg::word_t    rdata
);
    import mipsPkg::*;

    localparam int DmemAw = $clog2(`DMEM_WORDS);

    word_t mem [`DMEM_WORDS];
    logic [DmemAw-1:0] wordIdx;
    word_t memWord;
    logic [15:0] halfSel;
    logic [7:0] byteSel;

    assign wordIdx = addr[DmemAw+1:2];
    assign memWord = mem[wordIdx];
    assign halfSel = addr[1] ? memWord[31:16] : memWord[15:0];
    assign byteSel = memWord[8*addr[1:0] +: 8];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mem <= '{default: '0};
        end else if (en && we) begin
            case (size)
                MEM_HALF: mem[wordIdx][16*addr[1] +: 16] <= wdata[15:0];
                MEM_BYTE: mem[wordIdx][8*addr[1:0] +: 8] <= wdata[7:0];
                default:  mem[wordIdx] <= wdata;
            endcase
        end
    end

    // loads sign-extend the selected lane
    always_comb begin
        rdata = '0;
        if (en) begin
            case (size)
                MEM_HALF: rdata = {{16{halfSel[15]}}, halfSel};
                MEM_BYTE: rdata = {{24{byteSel[7]}}, byteSel};
                default:  rdata = memWord;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: Core.sv
`timescale 1ns/1ns
`default_nettype none
`include "mips_config.svh"

module Core (
    input  logic              clk,
    input  logic              arstN,
    input  logic              start,
    output logic              running,
    output logic              halted,
    input  logic              imemWe,
    input  mipsPkg::word_t    imemAddr, // word index
    input  mipsPkg::word_t    imemWdata,
    input  logic              hostMemEn,
    input  logic              hostMemWe,
    input  mipsPkg::word_t    hostMemAddr, // word index
    input  mipsPkg::word_t    hostMemWdata,
    output mipsPkg::word_t    hostMemRdata,
    input  mipsPkg::regAddr_t hostRegAddr,
    output mipsPkg::word_t    hostRegData
);
    import mipsPkg::*;

    localparam int ImemAw = $clog2(`IMEM_WORDS);

    word_t imem [`IMEM_WORDS];
    pc_t pc;
    pc_t pcPlus4;
    pc_t nextPc;
    pc_t branchTarget;
    pc_t jumpTarget;
    word_t immExt;
    word_t rsData;
    word_t rtData;
    word_t aluB;
    word_t aluResult;
    logic aluZero;
    logic aluNeg;
    logic branchTaken;
    word_t wbData;
    logic dmEn;
    logic dmWe;
    word_t dmAddr;
    word_t dmWdata;
    word_t dmRdata;
    memSize_t dmSize;

    ctrlIf ctrlBus ();

    always_ff @(posedge clk) begin
        if (imemWe) begin
            imem[imemAddr[ImemAw-1:0]] <= imemWdata;
        end
    end

    assign ctrlBus.instr = imem[pc[ImemAw+1:2]];

    Controller uCtrl (.instr(ctrlBus.instr), .ctrl(ctrlBus.decoder));

    always_comb begin
        case (ctrlBus.extMode)
            EXT_SIGN:  immExt = {{16{ctrlBus.imm16[15]}}, ctrlBus.imm16};
            EXT_UPPER: immExt = {ctrlBus.imm16, 16'h0000};
            default:   immExt = {16'h0000, ctrlBus.imm16};
        endcase
    end

    // bgtz and bgezal look at rs alone
    assign aluB = ctrlBus.aluSrc ? immExt :
                  (ctrlBus.bgtz || ctrlBus.bgezal) ? '0 : rtData;

    RegFile uRegs (
        .clk(clk), .arstN(arstN),
        .raddrA(ctrlBus.rs), .raddrB(ctrlBus.rt), .raddrHost(hostRegAddr),
        .rdataA(rsData), .rdataB(rtData), .rdataHost(hostRegData),
        .we(running && ctrlBus.regWrite), .waddr(ctrlBus.regAddr), .wdata(wbData)
    );

    Alu uAlu (
        .a(rsData), .b(aluB), .shamt(ctrlBus.shamt), .op(ctrlBus.aluOp),
        .result(aluResult), .zero(aluZero), .negative(aluNeg)
    );

    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {immExt[29:0], 2'b00};
    assign jumpTarget   = {pc[31:28], ctrlBus.imm26, 2'b00};
    assign branchTaken  = (ctrlBus.beq && aluZero)
                        || (ctrlBus.bgtz && !aluZero && !aluNeg)
                        || (ctrlBus.bgezal && !aluNeg);

    always_comb begin
        if (ctrlBus.jr || ctrlBus.jalr) nextPc = rsData;
        else if (ctrlBus.j || ctrlBus.jal) nextPc = jumpTarget;
        else if (branchTaken) nextPc = branchTarget;
        else nextPc = pcPlus4;
    end

    // host owns data memory while idle
    always_comb begin
        if (running) begin
            dmEn    = ctrlBus.memRead || ctrlBus.memWrite;
            dmWe    = ctrlBus.memWrite;
            dmAddr  = aluResult;
            dmSize  = ctrlBus.memSize;
            dmWdata = rtData;
        end else begin
            dmEn    = hostMemEn;
            dmWe    = hostMemWe;
            dmAddr  = {hostMemAddr[29:0], 2'b00};
            dmSize  = MEM_WORD;
            dmWdata = hostMemWdata;
        end
    end

    DataMem uDmem (
        .clk(clk), .arstN(arstN), .en(dmEn), .we(dmWe), .addr(dmAddr),
        .size(dmSize), .wdata(dmWdata), .rdata(dmRdata)
    );

    assign hostMemRdata = dmRdata;

    always_comb begin
        case (ctrlBus.wbSel)
            WB_MEM:  wbData = dmRdata;
            WB_LUI:  wbData = immExt;
            WB_LINK: wbData = pcPlus4;
            default: wbData = aluResult;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc      <= '0;
            running <= 1'b0;
            halted  <= 1'b0;
        end else if (start) begin
            pc      <= '0;
            running <= 1'b1;
            halted  <= 1'b0;
        end else if (running) begin
            if (ctrlBus.halt) begin
                running <= 1'b0;
                halted  <= 1'b1; // pc parks on the halt word
            end else begin
                pc <= nextPc;
            end
        end
    end

endmodule

`default_nettype wire

// File: ApbBridge.sv
`timescale 1ns/1ns
`default_nettype none
`include "mips_config.svh"

module ApbBridge (
    input  logic              clk,
    input  logic              arstN,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [11:0]       paddr,
    input  mipsPkg::word_t    pwdata,
    output mipsPkg::word_t    prdata,
    output logic              pready,
    output logic              pslverr,
    output logic              imemWe,
    output mipsPkg::word_t    imemAddr,
    output mipsPkg::word_t    imemWdata,
    output logic              hostMemEn,
    output logic              hostMemWe,
    output mipsPkg::word_t    hostMemAddr,
    output mipsPkg::word_t    hostMemWdata,
    input  mipsPkg::word_t    hostMemRdata,
    output logic              start,
    output mipsPkg::regAddr_t hostRegAddr,
    input  mipsPkg::word_t    hostRegData,
    input  logic              running,
    input  logic              halted
);
    import mipsPkg::*;

    apbState_t state;
    logic access;
    logic isImem, isDmem, isCtrl, isStatus, isReg;
    logic err;

    // state holds the phase of the previous cycle
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= APB_IDLE;
        end else if (psel && !penable) begin
            state <= APB_SETUP;
        end else if (psel && penable && (state == APB_SETUP)) begin
            state <= APB_ACCESS;
        end else begin
            state <= APB_IDLE;
        end
    end

    assign access = psel && penable && (state == APB_SETUP);

    assign isImem   = (paddr < `ADDR_IMEM_BASE + `IMEM_WORDS * 4);
    assign isDmem   = (paddr >= `ADDR_DMEM_BASE) && (paddr < `ADDR_DMEM_BASE + `DMEM_WORDS * 4);
    assign isCtrl   = (paddr == `ADDR_CTRL);
    assign isStatus = (paddr == `ADDR_STATUS);
    assign isReg    = (paddr >= `ADDR_REG_BASE) && (paddr < `ADDR_REG_BASE + `REG_WORDS * 4);

    assign err = !(isImem || isDmem || isCtrl || isStatus || isReg)
               || (pwrite && (isStatus || isReg))
               || ((isImem || isDmem) && running);

    assign pready  = access;
    assign pslverr = access && err;

    assign imemWe       = access && pwrite && isImem && !err;
    assign imemAddr     = word_t'(paddr[9:2]);
    assign imemWdata    = pwdata;
    assign hostMemEn    = access && isDmem && !err;
    assign hostMemWe    = hostMemEn && pwrite;
    assign hostMemAddr  = word_t'(paddr[9:2]);
    assign hostMemWdata = pwdata;
    assign hostRegAddr  = paddr[6:2];
    assign start        = access && pwrite && isCtrl && pwdata[0];

    always_comb begin
        prdata = '0;
        if (access && !pwrite && !err) begin
            if (isDmem) prdata = hostMemRdata;
            else if (isStatus) prdata = {30'b0, halted, running};
            else if (isReg) prdata = hostRegData;
        end
    end

endmodule

`default_nettype wire

// File: mipsTop.sv
`timescale 1ns/1ns
`default_nettype none

module mipsTop (
    input  logic           clk,
    input  logic           arstN,
    input  logic           psel,
    input  logic           penable,
    input  logic           pwrite,
    input  logic [11:0]    paddr,
    input  mipsPkg::word_t pwdata,
    output mipsPkg::word_t prdata,
    output logic           pready,
    output logic           pslverr
);
    import mipsPkg::*;

    logic imemWe;
    word_t imemAddr;
    word_t imemWdata;
    logic hostMemEn;
    logic hostMemWe;
    word_t hostMemAddr;
    word_t hostMemWdata;
    word_t hostMemRdata;
    logic start;
    regAddr_t hostRegAddr;
    word_t hostRegData;
    logic running;
    logic halted;

    ApbBridge uBridge (
        .clk(clk), .arstN(arstN), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .imemWe(imemWe), .imemAddr(imemAddr), .imemWdata(imemWdata),
        .hostMemEn(hostMemEn), .hostMemWe(hostMemWe), .hostMemAddr(hostMemAddr),
        .hostMemWdata(hostMemWdata), .hostMemRdata(hostMemRdata), .start(start),
        .hostRegAddr(hostRegAddr), .hostRegData(hostRegData),
        .running(running), .halted(halted)
    );

    Core uCore (
        .clk(clk), .arstN(arstN), .start(start), .running(running), .halted(halted),
        .imemWe(imemWe), .imemAddr(imemAddr), .imemWdata(imemWdata),
        .hostMemEn(hostMemEn), .hostMemWe(hostMemWe), .hostMemAddr(hostMemAddr),
        .hostMemWdata(hostMemWdata), .hostMemRdata(hostMemRdata),
        .hostRegAddr(hostRegAddr), .hostRegData(hostRegData)
    );

endmodule

`default_nettype wire

// File: tbMips.sv
`timescale 1ns/1ns
`default_nettype none

module tbMips;

    localparam int PollLimit  = 1000; // cycles to wait for halt
    localparam int ReadyLimit = 16;

    logic        clk;
    logic        arstN;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    integer fd;
    integer code;
    logic [7:0]  op;
    logic [31:0] fAddr;
    logic [31:0] fData;
    logic [31:0] fErr;
    logic [31:0] rdData;
    logic        rdErr;
    logic [8*256-1:0] skipLine;

    mipsTop uut (
        .clk(clk),
        .arstN(arstN),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic endInFailure();
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            endInFailure();
        end
    endtask

    task automatic needFields(input integer got, input integer want);
        if (got != want) begin
            $display("malformed trace line for operation '%c'", op);
            endInFailure();
        end
    endtask

    // one zero-wait APB transfer, sampled at the falling edge of the access phase
    task automatic apbTransfer(input logic write, input logic [31:0] addr,
                               input logic [31:0] data, output logic [31:0] rdata,
                               output logic err);
        int waitCycles;
        waitCycles = 0;
        @(posedge clk);
        psel    <= 1'b1; // setup phase
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr[11:0];
        pwdata  <= data;
        @(negedge clk);
        checkWord("pready in setup", {31'b0, pready}, 32'h0); // low outside access
        checkWord("pslverr in setup", {31'b0, pslverr}, 32'h0);
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready && waitCycles < ReadyLimit) begin
            @(negedge clk);
            waitCycles++;
        end
        if (!pready) begin
            $display("APB transfer to address %h never saw pready", addr[11:0]);
            endInFailure();
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic waitHalted();
        int cycles;
        logic [31:0] status;
        logic err;
        cycles = 0;
        status = '0;
        while (!status[1] && cycles < PollLimit) begin
            apbTransfer(1'b0, 32'h804, 32'h0, status, err);
            checkWord("pslverr", {31'b0, err}, 32'h0);
            cycles += 3; // each poll takes three clocks
        end
        if (!status[1]) begin
            $display("core did not halt within %0d cycles", PollLimit);
            endInFailure();
        end
    endtask

    initial begin
        arstN   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (16) @(posedge clk);
        arstN <= 1'b1;

        fd = $fopen("mips_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open mips_trace.txt");
            endInFailure();
        end

        code = $fscanf(fd, " %c", op);
        while (code == 1) begin
            case (op)
                "#": code = $fgets(skipLine, fd); // comment line
                "W": begin
                    code = $fscanf(fd, "%h %h %h", fAddr, fData, fErr);
                    needFields(code, 3);
                    apbTransfer(1'b1, fAddr, fData, rdData, rdErr);
                    checkWord($sformatf("pslverr @%h", fAddr[11:0]), {31'b0, rdErr}, fErr);
                end
                "R": begin
                    code = $fscanf(fd, "%h %h", fAddr, fData);
                    needFields(code, 2);
                    apbTransfer(1'b0, fAddr, 32'h0, rdData, rdErr);
                    checkWord($sformatf("pslverr @%h", fAddr[11:0]), {31'b0, rdErr}, 32'h0);
                    checkWord($sformatf("prdata @%h", fAddr[11:0]), rdData, fData);
                end
                "E": begin
                    code = $fscanf(fd, "%h", fAddr);
                    needFields(code, 1);
                    apbTransfer(1'b0, fAddr, 32'h0, rdData, rdErr);
                    checkWord($sformatf("pslverr @%h", fAddr[11:0]), {31'b0, rdErr}, 32'h1);
                end
                "P": waitHalted();
                default: begin
                    $display("unknown trace operation '%c'", op);
                    endInFailure();
                end
            endcase
            code = $fscanf(fd, " %c", op);
        end
        $fclose(fd);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: mipsCore.f
+incdir+.
mipsPkg.sv
ctrlIf.sv
Controller.sv
Alu.sv
RegFile.sv
DataMem.sv
Core.sv
ApbBridge.sv
mipsTop.sv
tbMips.sv

// File: mips_trace.txt
# W addr data err: APB write, err is the expected pslverr; R addr data: read and compare
# P: poll status until halted; E addr: read that must raise pslverr; all values hex
# state after reset
R 804 00000000
R C00 00000000
R C04 00000000
R C44 00000000
R C7C 00000000
# data memory preload through the host port
W 414 5555AAAA 0
W 418 AAAAAAAA 0
R 414 5555AAAA
R 418 AAAAAAAA
# program: addi ori lui add sub xor sll
W 000 2001FFFB 0
W 004 34028001 0
W 008 3C031234 0
W 00C 00222020 0
W 010 00412822 0
W 014 00623026 0
W 018 00023900 0
# stores and loads around base r8 = 0x10
W 01C 34080010 0
W 020 AD060000 0
W 024 A5010006 0
W 028 A1010009 0
W 02C A102000B 0
W 030 8D090000 0
W 034 850A0006 0
W 038 850B0000 0
W 03C 810C0009 0
W 040 810D000B 0
# beq taken, beq not taken, bgtz zero, bgtz positive
W 044 11260001 0
W 048 200E0001 0
W 04C 10220001 0
W 050 200F0002 0
W 054 1C000001 0
W 058 20100003 0
W 05C 1DE00001 0
W 060 20110004 0
# bgezal not taken then taken, both link
W 064 04310001 0
W 068 03E09020 0
W 06C 04110001 0
W 070 20110005 0
W 074 03E0B820 0
# jal to subroutine, jr back, j over code, jalr to halt
W 078 0C000021 0
W 07C 08000023 0
W 080 20130006 0
W 084 34140077 0
W 088 03E00008 0
W 08C 34160098 0
W 090 02C0A809 0
W 094 20130008 0
W 098 FC000000 0
# first run, data memory is locked while running
W 800 00000001 0
E 400
P
R 804 00000002
# register results
R C00 00000000
R C04 FFFFFFFB
R C08 00008001
R C0C 12340000
R C10 00007FFC
R C14 00008006
R C18 12348001
R C1C 00080010
R C20 00000010
R C24 12348001
R C28 FFFFFFFB
R C2C FFFF8001
R C30 FFFFFFFB
R C34 00000001
R C38 00000000
R C3C 00000002
R C40 00000003
R C44 00000000
R C48 00000068
R C4C 00000000
R C50 00000077
R C54 00000094
R C58 00000098
R C5C 00000070
R C7C 0000007C
# store lanes seen as whole words
R 410 12348001
R 414 FFFBAAAA
R 418 01AAFBAA
# bus errors
E 900
W 804 00000000 1
W C04 00000123 1
R C04 FFFFFFFB
# second run from pc 0
W 800 00000001 0
P
R 804 00000002
R C10 00007FFC
R C2C FFFF8001
R C54 00000094
R C5C 00000070
R C7C 0000007C
R 414 FFFBAAAA
R 418 01AAFBAA
